/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int data_width = 32;
    localparam int reg_count  = 32;

    // major opcodes, instr[31:26]
    localparam logic [5:0] op_r_type  = 6'b000000;
    localparam logic [5:0] op_branchs = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lb      = 6'b100000;
    localparam logic [5:0] op_lh      = 6'b100001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_lbu     = 6'b100100;
    localparam logic [5:0] op_lhu     = 6'b100101;
    localparam logic [5:0] op_sb      = 6'b101000;
    localparam logic [5:0] op_sh      = 6'b101001;
    localparam logic [5:0] op_sw      = 6'b101011;

    // r-type function field, instr[5:0]
    localparam logic [5:0] funct_sll   = 6'b000000;
    localparam logic [5:0] funct_srl   = 6'b000010;
    localparam logic [5:0] funct_sra   = 6'b000011;
    localparam logic [5:0] funct_sllv  = 6'b000100;
    localparam logic [5:0] funct_srlv  = 6'b000110;
    localparam logic [5:0] funct_srav  = 6'b000111;
    localparam logic [5:0] funct_jr    = 6'b001000;
    localparam logic [5:0] funct_mfhi  = 6'b010000;
    localparam logic [5:0] funct_mthi  = 6'b010001;
    localparam logic [5:0] funct_mflo  = 6'b010010;
    localparam logic [5:0] funct_mtlo  = 6'b010011;
    localparam logic [5:0] funct_mult  = 6'b011000;
    localparam logic [5:0] funct_multu = 6'b011001;
    localparam logic [5:0] funct_div   = 6'b011010;
    localparam logic [5:0] funct_divu  = 6'b011011;
    localparam logic [5:0] funct_add   = 6'b100000;
    localparam logic [5:0] funct_addu  = 6'b100001;
    localparam logic [5:0] funct_sub   = 6'b100010;
    localparam logic [5:0] funct_subu  = 6'b100011;
    localparam logic [5:0] funct_and   = 6'b100100;
    localparam logic [5:0] funct_or    = 6'b100101;
    localparam logic [5:0] funct_xor   = 6'b100110;
    localparam logic [5:0] funct_nor   = 6'b100111;
    localparam logic [5:0] funct_slt   = 6'b101010;
    localparam logic [5:0] funct_sltu  = 6'b101011;

    // regimm rt field selects the branch flavour
    localparam logic [4:0] rt_bltz = 5'b00000;
    localparam logic [4:0] rt_bgez = 5'b00001;

    typedef enum logic [4:0] {
        alu_and, alu_or, alu_xor, alu_nor,
        alu_add, alu_addu, alu_sub, alu_subu, alu_slt, alu_sltu,
        alu_sll_sa, alu_srl_sa, alu_sra_sa, alu_sll_v, alu_srl_v, alu_sra_v,
        alu_mfhi, alu_mflo, alu_mthi, alu_mtlo,
        alu_mult, alu_multu, alu_div, alu_divu,
        alu_lui, alu_nop
    } alu_op_t;

    // execute control, decoder to exec_unit
    typedef struct packed {
        logic    valid;
        alu_op_t alu_op;
        logic    use_imm;
        logic    imm_zero;
    } ex_ctrl_t;

    typedef struct packed {
        logic [data_width-1:0] rs_val;
        logic [data_width-1:0] rt_val;
        logic [15:0]           imm16;
        logic [4:0]            shamt;
    } ex_operands_t;

    // write-back strobe from the later stages
    typedef struct packed {
        logic                  en;
        logic [4:0]            addr;
        logic [data_width-1:0] data;
    } wb_port_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] value;
        logic                  overflow;
    } ex_result_t;

endpackage

`default_nettype wire

/* src/alu_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_decoder
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    output ex_ctrl_t    ex_ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    alu_op_t    alu_op_d;
    logic       use_imm_d;
    logic       imm_zero_d;
    ex_ctrl_t   ctrl_d;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        alu_op_d   = alu_nop;
        use_imm_d  = 1'b0;
        imm_zero_d = 1'b0;
        case (opcode)
            op_r_type: begin
                case (funct)
                    funct_and:   alu_op_d = alu_and;
                    funct_or:    alu_op_d = alu_or;
                    funct_xor:   alu_op_d = alu_xor;
                    funct_nor:   alu_op_d = alu_nor;
                    funct_add:   alu_op_d = alu_add;
                    funct_addu:  alu_op_d = alu_addu;
                    funct_sub:   alu_op_d = alu_sub;
                    funct_subu:  alu_op_d = alu_subu;
                    funct_slt:   alu_op_d = alu_slt;
                    funct_sltu:  alu_op_d = alu_sltu;
                    // constant-amount shifts then variable ones
                    funct_sll:   alu_op_d = alu_sll_sa;
                    funct_srl:   alu_op_d = alu_srl_sa;
                    funct_sra:   alu_op_d = alu_sra_sa;
                    funct_sllv:  alu_op_d = alu_sll_v;
                    funct_srlv:  alu_op_d = alu_srl_v;
                    funct_srav:  alu_op_d = alu_sra_v;
                    funct_mfhi:  alu_op_d = alu_mfhi;
                    funct_mflo:  alu_op_d = alu_mflo;
                    funct_mthi:  alu_op_d = alu_mthi;
                    funct_mtlo:  alu_op_d = alu_mtlo;
                    funct_mult:  alu_op_d = alu_mult;
                    funct_multu: alu_op_d = alu_multu;
                    funct_div:   alu_op_d = alu_div;
                    funct_divu:  alu_op_d = alu_divu;
                    funct_jr:    alu_op_d = alu_nop;
                    // unknown funct falls back to a plain add
                    default:     alu_op_d = alu_addu;
                endcase
            end
            op_addi: begin
                alu_op_d  = alu_add;
                use_imm_d = 1'b1;
            end
            op_addiu: begin
                alu_op_d  = alu_addu;
                use_imm_d = 1'b1;
            end
            op_slti: begin
                alu_op_d  = alu_slt;
                use_imm_d = 1'b1;
            end
            op_sltiu: begin
                alu_op_d  = alu_sltu;
                use_imm_d = 1'b1;
            end
            // logic immediates are zero-extended
            op_andi: begin
                alu_op_d   = alu_and;
                use_imm_d  = 1'b1;
                imm_zero_d = 1'b1;
            end
            op_ori: begin
                alu_op_d   = alu_or;
                use_imm_d  = 1'b1;
                imm_zero_d = 1'b1;
            end
            op_xori: begin
                alu_op_d   = alu_xor;
                use_imm_d  = 1'b1;
                imm_zero_d = 1'b1;
            end
            op_lui: begin
                alu_op_d  = alu_lui;
                use_imm_d = 1'b1;
            end
            // memory ops only need the effective address
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw: begin
                alu_op_d  = alu_add;
                use_imm_d = 1'b1;
            end
            // jumps and branches resolve outside execute and idle here
            default: alu_op_d = alu_nop;
        endcase
    end

    // a bubble carries nop so it cannot touch hi/lo
    always_comb begin
        ctrl_d.valid    = instr_valid;
        ctrl_d.alu_op   = instr_valid ? alu_op_d : alu_nop;
        ctrl_d.use_imm  = use_imm_d;
        ctrl_d.imm_zero = imm_zero_d;
    end

    // id/ex boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctrl <= '{valid: 1'b0, alu_op: alu_nop, use_imm: 1'b0, imm_zero: 1'b0};
        end else begin
            ex_ctrl <= ctrl_d;
        end
    end

endmodule

`default_nettype wire

/* src/operand_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_stage
    import mips_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  instr,
    input  wb_port_t     wb,
    output ex_operands_t ex_ops
);

    logic [4:0]            rs_addr;
    logic [4:0]            rt_addr;
    logic [data_width-1:0] regs [reg_count];
    logic [data_width-1:0] rs_val_d;
    logic [data_width-1:0] rt_val_d;
    ex_operands_t          ops_d;

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];

    // one read port: r0 is hardwired, a write in flight wins over the array
    function automatic logic [data_width-1:0] read_port(
        input logic [4:0]            addr,
        input logic [data_width-1:0] stored,
        input wb_port_t              wr
    );
        logic [data_width-1:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (wr.en && (wr.addr == addr)) begin
            val = wr.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    // register file, r0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rs_val_d = read_port(rs_addr, regs[rs_addr], wb);
        rt_val_d = read_port(rt_addr, regs[rt_addr], wb);
    end

    always_comb begin
        ops_d.rs_val = rs_val_d;
        ops_d.rt_val = rt_val_d;
        ops_d.imm16  = instr[15:0];
        ops_d.shamt  = instr[10:6];
    end

    // operand half of the id/ex register
    always_ff @(posedge clk) begin
        ex_ops <= ops_d;
    end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  ex_ctrl_t              ex_ctrl,
    input  ex_operands_t          ex_ops,
    output ex_result_t            result,
    output logic [data_width-1:0] hi,
    output logic [data_width-1:0] lo
);

    logic [data_width-1:0]   imm_ext;
    logic [data_width-1:0]   src_a;
    logic [data_width-1:0]   src_b;
    logic [data_width-1:0]   sum;
    logic [data_width-1:0]   diff;
    logic                    add_ovf;
    logic                    sub_ovf;
    logic [4:0]              var_sa;
    logic [2*data_width-1:0] prod_signed;
    logic [2*data_width-1:0] prod_unsigned;
    logic [data_width-1:0]   quot_signed;
    logic [data_width-1:0]   rem_signed;
    logic [data_width-1:0]   quot_unsigned;
    logic [data_width-1:0]   rem_unsigned;
    logic                    div_by_zero;
    logic [data_width-1:0]   value;
    logic                    overflow;

    // operand selection
    assign imm_ext = ex_ctrl.imm_zero ? {16'b0, ex_ops.imm16}
                                      : {{16{ex_ops.imm16[15]}}, ex_ops.imm16};
    assign src_a   = ex_ops.rs_val;
    assign src_b   = ex_ctrl.use_imm ? imm_ext : ex_ops.rt_val;

    assign sum  = src_a + src_b;
    assign diff = src_a - src_b;

    // signed overflow: operand signs agree (add) or differ (sub) and the result flips
    assign add_ovf = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
    assign sub_ovf = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);

    assign var_sa = ex_ops.rs_val[4:0];

    // mult/div always work on the two register operands
    assign prod_signed   = $signed({{32{ex_ops.rs_val[31]}}, ex_ops.rs_val})
                         * $signed({{32{ex_ops.rt_val[31]}}, ex_ops.rt_val});
    assign prod_unsigned = {32'b0, ex_ops.rs_val} * {32'b0, ex_ops.rt_val};

    assign div_by_zero   = (ex_ops.rt_val == '0);
    assign quot_signed   = $signed(ex_ops.rs_val) / $signed(ex_ops.rt_val);
    assign rem_signed    = $signed(ex_ops.rs_val) % $signed(ex_ops.rt_val);
    assign quot_unsigned = ex_ops.rs_val / ex_ops.rt_val;
    assign rem_unsigned  = ex_ops.rs_val % ex_ops.rt_val;

    always_comb begin
        value    = '0;
        overflow = 1'b0;
        case (ex_ctrl.alu_op)
            alu_and:  value = src_a & src_b;
            alu_or:   value = src_a | src_b;
            alu_xor:  value = src_a ^ src_b;
            alu_nor:  value = ~(src_a | src_b);
            alu_add: begin
                value    = sum;
                overflow = add_ovf;
            end
            alu_addu: value = sum;
            alu_sub: begin
                value    = diff;
                overflow = sub_ovf;
            end
            alu_subu: value = diff;
            alu_slt:  value = {31'b0, $signed(src_a) < $signed(src_b)};
            alu_sltu: value = {31'b0, src_a < src_b};
            // shifts always act on rt
            alu_sll_sa: value = ex_ops.rt_val << ex_ops.shamt;
            alu_srl_sa: value = ex_ops.rt_val >> ex_ops.shamt;
            alu_sra_sa: value = $signed(ex_ops.rt_val) >>> ex_ops.shamt;
            alu_sll_v:  value = ex_ops.rt_val << var_sa;
            alu_srl_v:  value = ex_ops.rt_val >> var_sa;
            alu_sra_v:  value = $signed(ex_ops.rt_val) >>> var_sa;
            alu_lui:    value = {ex_ops.imm16, 16'b0};
            alu_mfhi:   value = hi;
            alu_mflo:   value = lo;
            // moves to hi/lo, mult/div and nop produce no value
            default:    value = '0;
        endcase
    end

    always_comb begin
        result.valid    = ex_ctrl.valid;
        result.value    = value;
        result.overflow = overflow;
    end

    // hi/lo pair, written at the end of the execute cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (ex_ctrl.valid) begin
            case (ex_ctrl.alu_op)
                alu_mult:  {hi, lo} <= prod_signed;
                alu_multu: {hi, lo} <= prod_unsigned;
                alu_div: begin
                    if (!div_by_zero) begin
                        lo <= quot_signed;
                        hi <= rem_signed;
                    end
                end
                alu_divu: begin
                    if (!div_by_zero) begin
                        lo <= quot_unsigned;
                        hi <= rem_unsigned;
                    end
                end
                alu_mthi:  hi <= ex_ops.rs_val;
                alu_mtlo:  lo <= ex_ops.rs_val;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/id_ex_core.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_core
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           instr,
    input  logic                  instr_valid,
    input  wb_port_t              wb,
    output ex_result_t            result,
    output logic [data_width-1:0] hi,
    output logic [data_width-1:0] lo
);

    // id/ex boundary, split across the two decode-side blocks
    ex_ctrl_t     ex_ctrl;
    ex_operands_t ex_ops;

    alu_decoder u_alu_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ex_ctrl     (ex_ctrl)
    );

    operand_stage u_operand_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .wb     (wb),
        .ex_ops (ex_ops)
    );

    exec_unit u_exec_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_ctrl (ex_ctrl),
        .ex_ops  (ex_ops),
        .result  (result),
        .hi      (hi),
        .lo      (lo)
    );

endmodule

`default_nettype wire

/* testbench/tb_id_ex.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_ex
    import mips_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 4;

    // one table row holds instruction fields and register preload
    typedef struct packed {
        logic        valid;
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic        rand_ops;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
    } test_t;

    typedef struct packed {
        logic [31:0] value;
        logic        overflow;
        logic [31:0] hi;
        logic [31:0] lo;
    } model_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    wb_port_t    wb;
    ex_result_t  result;
    logic [31:0] hi;
    logic [31:0] lo;

    test_t       tests[$];
    logic        table_ready = 1'b0;
    logic [31:0] lfsr;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          test_base;
    int          timeout_cycles;

    id_ex_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb          (wb),
        .result      (result),
        .hi          (hi),
        .lo          (lo)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_word(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[30:0], lfsr[0]};
        end
    endtask

    task automatic add_test(input logic valid, input logic [5:0] opcode,
                            input logic [5:0] funct, input logic [4:0] rs,
                            input logic [4:0] rt, input logic [15:0] imm,
                            input logic rand_ops, input logic [31:0] rs_data,
                            input logic [31:0] rt_data);
        test_t t;
        t = {valid, opcode, funct, rs, rt, imm, rand_ops, rs_data, rt_data};
        tests.push_back(t);
    endtask

    function automatic logic [31:0] build_instr(input test_t t);
        logic [31:0] word;
        if (t.opcode == op_r_type) begin
            word = {t.opcode, t.rs, t.rt, 5'd2, t.imm[4:0], t.funct};
        end else begin
            word = {t.opcode, t.rs, t.rt, t.imm};
        end
        return word;
    endfunction

    function automatic logic [31:0] hilo_read(input logic [5:0] funct);
        return {op_r_type, 15'd0, 5'd0, funct};
    endfunction

    // expected execute outcome per the instruction set rules
    function automatic model_t reference_model(input test_t t, input logic [31:0] a,
                                               input logic [31:0] b,
                                               input logic [31:0] hi_in,
                                               input logic [31:0] lo_in);
        model_t      m;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [32:0] wide;
        longint      sprod;
        logic [63:0] uprod;
        int          sa;
        int          sb;
        m = {32'h0, 1'b0, hi_in, lo_in};
        simm = {{16{t.imm[15]}}, t.imm};
        zimm = {16'h0, t.imm};
        sa = a;
        sb = b;
        if (!t.valid) begin
            return m;
        end
        case (t.opcode)
            op_r_type: begin
                case (t.funct)
                    funct_and:  m.value = a & b;
                    funct_or:   m.value = a | b;
                    funct_xor:  m.value = a ^ b;
                    funct_nor:  m.value = ~(a | b);
                    funct_add: begin
                        wide = {a[31], a} + {b[31], b};
                        m.value = wide[31:0];
                        m.overflow = wide[32] ^ wide[31];
                    end
                    funct_sub: begin
                        wide = {a[31], a} - {b[31], b};
                        m.value = wide[31:0];
                        m.overflow = wide[32] ^ wide[31];
                    end
                    funct_subu: m.value = a - b;
                    funct_slt:  m.value = (sa < sb) ? 32'd1 : 32'd0;
                    funct_sltu: m.value = (a < b) ? 32'd1 : 32'd0;
                    funct_sll:  m.value = b << t.imm[4:0];
                    funct_srl:  m.value = b >> t.imm[4:0];
                    funct_sra:  m.value = sb >>> t.imm[4:0];
                    funct_sllv: m.value = b << a[4:0];
                    funct_srlv: m.value = b >> a[4:0];
                    funct_srav: m.value = sb >>> a[4:0];
                    funct_mfhi: m.value = hi_in;
                    funct_mflo: m.value = lo_in;
                    funct_mthi: m.hi = a;
                    funct_mtlo: m.lo = a;
                    funct_mult: begin
                        sprod = longint'(sa) * longint'(sb);
                        {m.hi, m.lo} = sprod;
                    end
                    funct_multu: begin
                        uprod = {32'h0, a} * {32'h0, b};
                        {m.hi, m.lo} = uprod;
                    end
                    // quotient truncates toward zero and the remainder takes the dividend sign
                    funct_div: begin
                        if (b != 32'h0) begin
                            m.lo = sa / sb;
                            m.hi = sa % sb;
                        end
                    end
                    funct_divu: begin
                        if (b != 32'h0) begin
                            m.lo = a / b;
                            m.hi = a % b;
                        end
                    end
                    funct_jr:   m.value = 32'h0;
                    default:    m.value = a + b;
                endcase
            end
            op_addi: begin
                wide = {a[31], a} + {simm[31], simm};
                m.value = wide[31:0];
                m.overflow = wide[32] ^ wide[31];
            end
            op_addiu: m.value = a + simm;
            op_slti:  m.value = (sa < int'(simm)) ? 32'd1 : 32'd0;
            op_sltiu: m.value = (a < simm) ? 32'd1 : 32'd0;
            op_andi:  m.value = a & zimm;
            op_ori:   m.value = a | zimm;
            op_xori:  m.value = a ^ zimm;
            op_lui:   m.value = {t.imm, 16'h0};
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw: m.value = a + simm;
            default:  m.value = 32'h0;
        endcase
        return m;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string label);
        if (error_count == test_base) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fail_count++;
            $display("%s: mismatch", label);
        end
        test_base = error_count;
    endtask

    // the trailing MFLO of a test lands one cycle into the next
    task automatic close_test(input int idx);
        check_value("mflo value", result.value, model_lo);
        report_test($sformatf("test %0d op %02h funct %02h", idx, tests[idx].opcode,
                              tests[idx].funct));
    endtask

    task automatic apply_test(input int idx);
        test_t       t;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] a;
        logic [31:0] b;
        model_t      m;
        t = tests[idx];
        rs_data = t.rs_data;
        rt_data = t.rt_data;
        if (t.rand_ops) begin
            random_word(rs_data);
            random_word(rt_data);
        end
        // rs goes in a cycle early
        @(posedge clk);
        #2;
        wb = '{en: 1'b1, addr: t.rs, data: rs_data};
        instr = '0;
        instr_valid = 1'b0;
        @(negedge clk);
        if (idx > 0) begin
            close_test(idx - 1);
        end
        // rt reaches the instruction through the bypass
        @(posedge clk);
        #2;
        wb = '{en: 1'b1, addr: t.rt, data: rt_data};
        instr = build_instr(t);
        instr_valid = t.valid;
        @(posedge clk);
        #2;
        wb = '0;
        instr = hilo_read(funct_mfhi);
        instr_valid = 1'b1;
        a = (t.rs == 5'd0) ? 32'h0 : ((t.rs == t.rt) ? rt_data : rs_data);
        b = (t.rt == 5'd0) ? 32'h0 : rt_data;
        m = reference_model(t, a, b, model_hi, model_lo);
        @(negedge clk);
        check_value("result.valid", {31'b0, result.valid}, {31'b0, t.valid});
        check_value("result.value", result.value, m.value);
        check_value("result.overflow", {31'b0, result.overflow}, {31'b0, m.overflow});
        model_hi = m.hi;
        model_lo = m.lo;
        @(posedge clk);
        #2;
        instr = hilo_read(funct_mflo);
        @(negedge clk);
        check_value("hi", hi, model_hi);
        check_value("lo", lo, model_lo);
        check_value("mfhi value", result.value, model_hi);
    endtask

    task automatic build_table();
        // r-type logic and arithmetic
        add_test(1'b1, op_r_type, funct_and, 5'd4, 5'd5, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_or, 5'd6, 5'd7, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_xor, 5'd8, 5'd9, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_nor, 5'd10, 5'd11, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_addu, 5'd12, 5'd13, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_subu, 5'd14, 5'd15, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_slt, 5'd16, 5'd17, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_sltu, 5'd18, 5'd19, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, 6'h3f, 5'd20, 5'd21, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_add, 5'd4, 5'd5, 16'h0, 1'b1, 32'h0, 32'h0);
        // signed overflow at both boundaries
        add_test(1'b1, op_r_type, funct_add, 5'd4, 5'd5, 16'h0, 1'b0, 32'h7fffffff, 32'h1);
        add_test(1'b1, op_r_type, funct_add, 5'd4, 5'd5, 16'h0, 1'b0, 32'h80000000,
                 32'hffffffff);
        add_test(1'b1, op_r_type, funct_sub, 5'd6, 5'd7, 16'h0, 1'b0, 32'h7fffffff,
                 32'hffffffff);
        add_test(1'b1, op_r_type, funct_sub, 5'd6, 5'd7, 16'h0, 1'b0, 32'h80000000, 32'h1);
        // immediates
        add_test(1'b1, op_addi, 6'd0, 5'd8, 5'd9, 16'hfff0, 1'b0, 32'h10, 32'h0);
        add_test(1'b1, op_addi, 6'd0, 5'd8, 5'd9, 16'h0001, 1'b0, 32'h7fffffff, 32'h0);
        add_test(1'b1, op_addiu, 6'd0, 5'd8, 5'd9, 16'h8000, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_andi, 6'd0, 5'd10, 5'd11, 16'hf0f0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_ori, 6'd0, 5'd10, 5'd11, 16'h8001, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_xori, 6'd0, 5'd10, 5'd11, 16'hffff, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_slti, 6'd0, 5'd12, 5'd13, 16'hfffd, 1'b0, 32'hfffffffb, 32'h0);
        add_test(1'b1, op_sltiu, 6'd0, 5'd12, 5'd13, 16'hffff, 1'b0, 32'h5, 32'h0);
        add_test(1'b1, op_lui, 6'd0, 5'd12, 5'd13, 16'hbeef, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_lw, 6'd0, 5'd14, 5'd15, 16'hfffc, 1'b0, 32'h1000, 32'h0);
        add_test(1'b1, op_sb, 6'd0, 5'd14, 5'd15, 16'h0004, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_lhu, 6'd0, 5'd14, 5'd15, 16'h8000, 1'b0, 32'h10000, 32'h0);
        // shifts with shamt in the low imm bits
        add_test(1'b1, op_r_type, funct_sll, 5'd16, 5'd17, 16'd4, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_srl, 5'd16, 5'd17, 16'd31, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_sra, 5'd16, 5'd17, 16'd8, 1'b0, 32'h0, 32'h80001234);
        add_test(1'b1, op_r_type, funct_sllv, 5'd18, 5'd19, 16'h0, 1'b0, 32'h23, 32'hff);
        add_test(1'b1, op_r_type, funct_srlv, 5'd18, 5'd19, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_srav, 5'd18, 5'd19, 16'h0, 1'b0, 32'h1f, 32'h80000000);
        // multiply, divide and moves
        add_test(1'b1, op_r_type, funct_mult, 5'd20, 5'd21, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_multu, 5'd20, 5'd21, 16'h0, 1'b0, 32'hffffffff,
                 32'hffffffff);
        add_test(1'b1, op_r_type, funct_div, 5'd22, 5'd23, 16'h0, 1'b0, 32'hfffffff9, 32'h2);
        add_test(1'b1, op_r_type, funct_divu, 5'd22, 5'd23, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_div, 5'd22, 5'd23, 16'h0, 1'b0, 32'h12345678, 32'h0);
        add_test(1'b1, op_r_type, funct_mthi, 5'd24, 5'd25, 16'h0, 1'b0, 32'hcafef00d, 32'h0);
        add_test(1'b1, op_r_type, funct_mtlo, 5'd24, 5'd25, 16'h0, 1'b0, 32'h0badcafe, 32'h0);
        // register 0 and same-register writes
        add_test(1'b1, op_r_type, funct_or, 5'd0, 5'd5, 16'h0, 1'b0, 32'hffffffff, 32'hf0f);
        add_test(1'b1, op_r_type, funct_addu, 5'd5, 5'd0, 16'h0, 1'b0, 32'h1, 32'h12345678);
        add_test(1'b1, op_r_type, funct_addu, 5'd9, 5'd9, 16'h0, 1'b0, 32'h1, 32'h5);
        // jumps, branches and a bubble
        add_test(1'b1, op_j, 6'd0, 5'd4, 5'd5, 16'h1234, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_r_type, funct_jr, 5'd4, 5'd5, 16'h0, 1'b1, 32'h0, 32'h0);
        add_test(1'b1, op_branchs, 6'd0, 5'd6, rt_bgez, 16'h0010, 1'b1, 32'h0, 32'h0);
        add_test(1'b0, op_r_type, funct_mult, 5'd20, 5'd21, 16'h0, 1'b1, 32'h0, 32'h0);
    endtask

    initial begin
        rst_n = 1'b0;
        // a valid instruction stays pending so only reset keeps execute idle
        instr = hilo_read(funct_mfhi);
        instr_valid = 1'b1;
        wb = '0;
        lfsr = 32'd88875;
        model_hi = '0;
        model_lo = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        test_base = 0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        @(negedge clk);
        check_value("result.valid", {31'b0, result.valid}, 32'h0);
        check_value("hi", hi, 32'h0);
        check_value("lo", lo, 32'h0);
        report_test("reset");
        for (int i = 0; i < tests.size(); i++) begin
            apply_test(i);
        end
        @(posedge clk);
        #2;
        wb = '0;
        instr = '0;
        instr_valid = 1'b0;
        @(negedge clk);
        close_test(tests.size() - 1);
        $display("tests passed %0d, failed %0d, mismatching checks %0d", pass_count,
                 fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // four cycles per table row plus reset and some slack
    initial begin
        wait (table_ready);
        timeout_cycles = tests.size() * 4 + reset_cycles + 8;
        #(timeout_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/mips_pkg.sv
src/alu_decoder.sv
src/operand_stage.sv
src/exec_unit.sv
src/id_ex_core.sv
testbench/tb_id_ex.sv

/* build.sh */
#!/bin/sh
# compile the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f all.f --top-module tb_id_ex -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$build_dir/Vtb_id_ex" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$log_file"; then
    echo "simulation log has no final status"
    exit 1
fi
exit 0
